// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int INSTR_W = 32;
  localparam int DATA_W  = 32;
  localparam int REG_AW  = 4;
  localparam int IMM_W   = 12;

  localparam int TYPE_LSB = 28;
  localparam int OP_LSB   = 24;
  localparam int RA_LSB   = 20;
  localparam int RB_LSB   = 16;
  localparam int RC_LSB   = 12;

  localparam logic [INSTR_W-1:0] NOP_INSTR = '0;

  // codes kept from the full ISA, any other type does nothing
  typedef enum logic [3:0] {
    T_MOV   = 4'h4,
    T_ALU   = 4'h6,
    T_LOAD  = 4'h9,
    T_STORE = 4'ha
  } instr_type_e;

  // low three op bits, bit 3 swaps rc for the immediate
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_PASSB
  } alu_op_e;

  function automatic instr_type_e ir_type(input logic [INSTR_W-1:0] ir);
    return instr_type_e'(ir[TYPE_LSB +: 4]);
  endfunction

  function automatic alu_op_e ir_alu_op(input logic [INSTR_W-1:0] ir);
    return alu_op_e'({1'b0, ir[OP_LSB +: 3]});
  endfunction

  function automatic logic ir_imm_sel(input logic [INSTR_W-1:0] ir);
    return ir[OP_LSB + 3];
  endfunction

  function automatic logic [REG_AW-1:0] ir_ra(input logic [INSTR_W-1:0] ir);
    return ir[RA_LSB +: REG_AW];
  endfunction

  function automatic logic [REG_AW-1:0] ir_rb(input logic [INSTR_W-1:0] ir);
    return ir[RB_LSB +: REG_AW];
  endfunction

  function automatic logic [REG_AW-1:0] ir_rc(input logic [INSTR_W-1:0] ir);
    return ir[RC_LSB +: REG_AW];
  endfunction

  function automatic logic [DATA_W-1:0] ir_imm(input logic [INSTR_W-1:0] ir);
    return {{(DATA_W - IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};
  endfunction

  // ALU, MOV and LOAD all write ra
  function automatic logic ir_writes(input logic [INSTR_W-1:0] ir);
    instr_type_e t;
    t = ir_type(ir);
    return t == T_ALU || t == T_MOV || t == T_LOAD;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // operand source picked by the hazard unit
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EXE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // input queue, also the sender's starting credit count
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_AW    = 2;

  localparam int RET_DEPTH   = 4;
  localparam int RET_AW      = 2;
  localparam int RET_CREDITS = 2;

  // wide enough for every count and credit counter
  localparam int CREDIT_W = 3;

  // data RAM word address
  localparam int RAM_AW = 6;

endpackage

`default_nettype wire

// ==== rtl/instr_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_queue (
  input  wire                          clk_i,
  input  wire                          rst,
  input  wire                          in_valid,
  input  wire  [isa_pkg::INSTR_W-1:0]  in_instr,
  input  wire                          pop,
  output logic                         head_valid,
  output logic [isa_pkg::INSTR_W-1:0]  head_instr,
  output logic                         in_credit
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [INSTR_W-1:0]  entries [QUEUE_DEPTH];
  logic [QUEUE_AW-1:0] wr_ptr;
  logic [QUEUE_AW-1:0] rd_ptr;
  logic [CREDIT_W-1:0] count;
  logic                push;
  logic                take;

  assign push       = in_valid && (count != CREDIT_W'(QUEUE_DEPTH));
  assign take       = pop && head_valid;
  assign head_valid = count != '0;
  assign head_instr = entries[rd_ptr];

  // one credit goes back for every entry handed to decode
  assign in_credit = take;

  always_ff @(posedge clk_i)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (take)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      entries[wr_ptr] <= in_instr;
  end

endmodule

`default_nettype wire

// ==== rtl/hazard.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard (
  input  wire                          [isa_pkg::INSTR_W-1:0] if_ir,
  input  wire                          [isa_pkg::INSTR_W-1:0] id_ir,
  input  wire                          [isa_pkg::INSTR_W-1:0] exe_ir,
  input  wire                          [isa_pkg::INSTR_W-1:0] mem_ir,
  input  wire                          exe_reg_write,
  input  wire                          mem_reg_write,
  input  wire                          wb_reg_write,
  input  wire  [isa_pkg::REG_AW-1:0]   wb_reg_write_addr,
  output logic                         stall,
  output pipe_pkg::fwd_sel_e           fwd_a,
  output pipe_pkg::fwd_sel_e           fwd_b
);
  import isa_pkg::*;
  import pipe_pkg::*;

  instr_type_e       if_type;
  instr_type_e       id_type;
  logic [REG_AW-1:0] load_ra;
  logic              reads_load;

  assign if_type = ir_type(if_ir);
  assign id_type = ir_type(id_ir);
  assign load_ra = ir_ra(id_ir);

  // a store right behind the load needs ra as its data too
  assign reads_load = load_ra == ir_rb(if_ir) ||
                      load_ra == ir_rc(if_ir) ||
                      (if_type == T_STORE && load_ra == ir_ra(if_ir));

  assign stall = id_type == T_LOAD && if_ir != NOP_INSTR && reads_load;

  // youngest writer wins
  function automatic fwd_sel_e pick(input logic [REG_AW-1:0] src);
    if (exe_reg_write && ir_ra(exe_ir) == src)
      return FWD_EXE;
    if (mem_reg_write && ir_ra(mem_ir) == src)
      return FWD_MEM;
    if (wb_reg_write && wb_reg_write_addr == src)
      return FWD_WB;
    return FWD_NONE;
  endfunction

  always_comb
  begin
    case (id_type)
      T_ALU:
      begin
        fwd_a = pick(ir_rb(id_ir));
        fwd_b = ir_imm_sel(id_ir) ? FWD_NONE : pick(ir_rc(id_ir));
      end
      T_MOV:
      begin
        fwd_a = pick(ir_rb(id_ir));
        fwd_b = FWD_NONE;
      end
      T_STORE:
      begin
        fwd_a = pick(ir_ra(id_ir));
        fwd_b = pick(ir_rb(id_ir));
      end
      T_LOAD:
      begin
        fwd_a = FWD_NONE;
        fwd_b = pick(ir_rb(id_ir));
      end
      default:
      begin
        fwd_a = FWD_NONE;
        fwd_b = FWD_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exec_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_pipe (
  input  wire                          clk_i,
  input  wire                          rst,
  input  wire                          head_valid,
  input  wire  [isa_pkg::INSTR_W-1:0]  head_instr,
  input  wire                          advance,
  input  wire                          stall,
  input  wire  pipe_pkg::fwd_sel_e     fwd_a,
  input  wire  pipe_pkg::fwd_sel_e     fwd_b,
  output logic                         pop,
  output logic [isa_pkg::INSTR_W-1:0]  if_ir,
  output logic [isa_pkg::INSTR_W-1:0]  id_ir,
  output logic [isa_pkg::INSTR_W-1:0]  exe_ir,
  output logic [isa_pkg::INSTR_W-1:0]  mem_ir,
  output logic                         exe_reg_write,
  output logic                         mem_reg_write,
  output logic                         wb_reg_write,
  output logic [isa_pkg::REG_AW-1:0]   wb_reg_write_addr,
  output logic                         wb_valid,
  output logic [isa_pkg::REG_AW-1:0]   wb_addr,
  output logic [isa_pkg::DATA_W-1:0]   wb_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [DATA_W-1:0] regs [2**REG_AW];
  logic [DATA_W-1:0] ram  [2**RAM_AW];

  instr_type_e       id_type;
  logic [REG_AW-1:0] id_src_a;
  logic [REG_AW-1:0] id_src_b;
  logic [DATA_W-1:0] id_a;
  logic [DATA_W-1:0] id_b;

  instr_type_e       exe_type;
  alu_op_e           exe_op;
  logic [DATA_W-1:0] exe_a;
  logic [DATA_W-1:0] exe_b;
  logic [DATA_W-1:0] exe_alu;
  logic [DATA_W-1:0] exe_result;
  logic [RAM_AW-1:0] exe_addr;

  logic [DATA_W-1:0] mem_result;
  logic [DATA_W-1:0] mem_load;
  logic [DATA_W-1:0] mem_data;

  function automatic logic [DATA_W-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [DATA_W-1:0] rf,
                                                input logic [DATA_W-1:0] ex,
                                                input logic [DATA_W-1:0] mm,
                                                input logic [DATA_W-1:0] wb);
    case (sel)
      FWD_EXE: return ex;
      FWD_MEM: return mm;
      FWD_WB:  return wb;
      default: return rf;
    endcase
  endfunction

  // fetch is the queue head
  assign if_ir = head_valid ? head_instr : NOP_INSTR;
  assign pop   = head_valid && advance && !stall;

  // decode: store data comes from ra, load and store address from rb
  assign id_type  = ir_type(id_ir);
  assign id_src_a = (id_type == T_STORE) ? ir_ra(id_ir) : ir_rb(id_ir);
  assign id_src_b = (id_type == T_ALU) ? ir_rc(id_ir) : ir_rb(id_ir);
  assign id_a     = fwd_mux(fwd_a, regs[id_src_a], exe_result, mem_data, wb_data);

  always_comb
  begin
    if (id_type == T_ALU && ir_imm_sel(id_ir))
      id_b = ir_imm(id_ir);
    else
      id_b = fwd_mux(fwd_b, regs[id_src_b], exe_result, mem_data, wb_data);
  end

  assign exe_type = ir_type(exe_ir);
  assign exe_op   = ir_alu_op(exe_ir);
  assign exe_addr = RAM_AW'(exe_b + ir_imm(exe_ir));

  always_comb
  begin
    case (exe_op)
      ALU_ADD: exe_alu = exe_a + exe_b;
      ALU_SUB: exe_alu = exe_a - exe_b;
      ALU_AND: exe_alu = exe_a & exe_b;
      ALU_OR:  exe_alu = exe_a | exe_b;
      ALU_XOR: exe_alu = exe_a ^ exe_b;
      ALU_SHL: exe_alu = exe_a << exe_b[4:0];
      ALU_SHR: exe_alu = exe_a >> exe_b[4:0];
      default: exe_alu = exe_b;
    endcase
  end

  // MOV passes rb through on the a side
  assign exe_result = (exe_type == T_MOV) ? exe_a : exe_alu;

  // load data arrives from the RAM one stage after the address
  assign mem_data = (ir_type(mem_ir) == T_LOAD) ? mem_load : mem_result;

  assign exe_reg_write     = ir_writes(exe_ir);
  assign mem_reg_write     = ir_writes(mem_ir);
  assign wb_reg_write      = wb_valid;
  assign wb_reg_write_addr = wb_addr;

  always_ff @(posedge clk_i)
  begin
    if (rst)
    begin
      id_ir    <= NOP_INSTR;
      exe_ir   <= NOP_INSTR;
      mem_ir   <= NOP_INSTR;
      wb_valid <= 1'b0;
    end
    else if (advance)
    begin
      // on a stall the head stays put and a bubble follows the load
      id_ir    <= pop ? head_instr : NOP_INSTR;
      exe_ir   <= id_ir;
      mem_ir   <= exe_ir;
      wb_valid <= mem_reg_write;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      exe_a      <= id_a;
      exe_b      <= id_b;
      mem_result <= exe_result;
      mem_load   <= ram[exe_addr];
      wb_addr    <= ir_ra(mem_ir);
      wb_data    <= mem_data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst)
    begin
      for (int i = 0; i < 2**REG_AW; i++)
        regs[i] <= '0;
      for (int i = 0; i < 2**RAM_AW; i++)
        ram[i] <= '0;
    end
    else if (advance)
    begin
      if (wb_valid)
        regs[wb_addr] <= wb_data;
      if (exe_type == T_STORE)
        ram[exe_addr] <= exe_a;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/retire_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_port (
  input  wire                          clk_i,
  input  wire                          rst,
  input  wire                          wb_valid,
  input  wire  [isa_pkg::REG_AW-1:0]   wb_addr,
  input  wire  [isa_pkg::DATA_W-1:0]   wb_data,
  input  wire                          ret_credit,
  output logic                         advance,
  output logic                         ret_valid,
  output logic [isa_pkg::REG_AW-1:0]   ret_addr,
  output logic [isa_pkg::DATA_W-1:0]   ret_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [REG_AW-1:0]   buf_addr [RET_DEPTH];
  logic [DATA_W-1:0]   buf_data [RET_DEPTH];
  logic [RET_AW-1:0]   wr_ptr;
  logic [RET_AW-1:0]   rd_ptr;
  logic [CREDIT_W-1:0] count;
  logic [CREDIT_W-1:0] credits;
  logic                push;

  // a full buffer freezes the whole pipe
  assign advance = count != CREDIT_W'(RET_DEPTH);
  assign push    = wb_valid && advance;

  assign ret_valid = count != '0 && credits != '0;
  assign ret_addr  = buf_addr[rd_ptr];
  assign ret_data  = buf_data[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (rst)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CREDIT_W'(RET_CREDITS);
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (ret_valid)
        rd_ptr <= rd_ptr + 1'b1;
      count   <= count + CREDIT_W'(push) - CREDIT_W'(ret_valid);
      credits <= credits + CREDIT_W'(ret_credit) - CREDIT_W'(ret_valid);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      buf_addr[wr_ptr] <= wb_addr;
      buf_data[wr_ptr] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_top (
  input  wire                          clk_i,
  input  wire                          rst,
  input  wire                          in_valid,
  input  wire  [isa_pkg::INSTR_W-1:0]  in_instr,
  output logic                         in_credit,
  output logic                         ret_valid,
  output logic [isa_pkg::REG_AW-1:0]   ret_addr,
  output logic [isa_pkg::DATA_W-1:0]   ret_data,
  input  wire                          ret_credit
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic               head_valid;
  logic [INSTR_W-1:0] head_instr;
  logic               pop;
  logic               advance;
  logic               stall;
  fwd_sel_e           fwd_a;
  fwd_sel_e           fwd_b;

  logic [INSTR_W-1:0] if_ir;
  logic [INSTR_W-1:0] id_ir;
  logic [INSTR_W-1:0] exe_ir;
  logic [INSTR_W-1:0] mem_ir;
  logic               exe_reg_write;
  logic               mem_reg_write;
  logic               wb_reg_write;
  logic [REG_AW-1:0]  wb_reg_write_addr;

  logic               wb_valid;
  logic [REG_AW-1:0]  wb_addr;
  logic [DATA_W-1:0]  wb_data;

  instr_queue queue_i (.*);

  exec_pipe pipe_i (.*);

  hazard hazard_i (.*);

  // retire back-pressure reaches the input credits through advance
  retire_port retire_i (.*);

endmodule

`default_nettype wire

// ==== tb/core_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_properties (
  input wire                                 clk_i,
  input wire                                 rst,
  input wire                                 in_valid,
  input wire                                 in_credit,
  input wire                                 ret_valid,
  input wire                                 ret_credit,
  input wire [isa_pkg::INSTR_W-1:0]          exe_ir,
  input wire pipe_pkg::fwd_sel_e             fwd_a,
  input wire pipe_pkg::fwd_sel_e             fwd_b,
  input wire [pipe_pkg::CREDIT_W-1:0]        queue_count
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic                seen_push;
  logic [CREDIT_W-1:0] held_credits;

  always_ff @(posedge clk_i)
  begin
    if (rst)
      seen_push <= 1'b0;
    else if (in_valid)
      seen_push <= 1'b1;
  end

  // credits the receiver has granted and the core has not spent yet
  always_ff @(posedge clk_i)
  begin
    if (rst)
      held_credits <= CREDIT_W'(RET_CREDITS);
    else
      held_credits <= held_credits + CREDIT_W'(ret_credit) - CREDIT_W'(ret_valid);
  end

  no_push_when_full: assert property (@(posedge clk_i) disable iff (rst)
    in_valid |-> queue_count != CREDIT_W'(QUEUE_DEPTH))
    else $error("push into a full input queue");

  no_retire_without_credit: assert property (@(posedge clk_i) disable iff (rst)
    ret_valid |-> held_credits != '0)
    else $error("ret_valid with no retire credit");

  quiet_until_push: assert property (@(posedge clk_i) disable iff (rst)
    !seen_push |-> !in_credit && !ret_valid)
    else $error("output activity before the first push");

  // load data is not ready in execute so the stall keeps its readers back
  load_use_stalled: assert property (@(posedge clk_i) disable iff (rst)
    exe_ir[TYPE_LSB +: 4] == T_LOAD |-> fwd_a != FWD_EXE && fwd_b != FWD_EXE)
    else $error("operand forwarded from a load still in execute");

endmodule

bind core_top core_properties props_i (
  .clk_i       (clk_i),
  .rst         (rst),
  .in_valid    (in_valid),
  .in_credit   (in_credit),
  .ret_valid   (ret_valid),
  .ret_credit  (ret_credit),
  .exe_ir      (exe_ir),
  .fwd_a       (fwd_a),
  .fwd_b       (fwd_b),
  .queue_count (queue_i.count)
);

`default_nettype wire

// ==== tb/tb_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_core;
  import isa_pkg::*;
  import pipe_pkg::*;

  logic               clk_i;
  logic               rst;
  logic               in_valid;
  logic [INSTR_W-1:0] in_instr;
  logic               ret_credit;
  wire                in_credit;
  wire                ret_valid;
  wire  [REG_AW-1:0]  ret_addr;
  wire  [DATA_W-1:0]  ret_data;

  logic [31:0] rng_state;
  logic [31:0] send_q [$];
  logic [3:0]  exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] mregs [16];
  logic [31:0] mmem [64];
  int credits;
  int owed;
  int hold_left;
  int errors;
  int pass_count;
  int fail_count;
  int cycles;
  int sent_total;
  // 0 returns credits at once, 1 at random, 2 withholds in stretches
  int return_mode;
  bit send_random;

  core_top core_top_i (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 16) % n);
  endfunction

  function automatic logic [31:0] make_instr(input logic [3:0] t, input logic [3:0] op,
                                             input logic [3:0] ra, input logic [3:0] rb,
                                             input logic [3:0] rc, input logic [11:0] imm);
    return {t, op, ra, rb, rc, imm};
  endfunction

  function automatic void model_write(input logic [3:0] ra, input logic [31:0] v);
    mregs[ra] = v;
    exp_addr.push_back(ra);
    exp_data.push_back(v);
  endfunction

  // in-order reference execution of one instruction
  function automatic void model_step(input logic [31:0] ir);
    logic [3:0]  t;
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] r;
    logic [5:0]  addr;
    t    = ir[31:28];
    op   = ir[27:24];
    imm  = {{20{ir[11]}}, ir[11:0]};
    a    = mregs[ir[19:16]];
    b    = op[3] ? imm : mregs[ir[15:12]];
    addr = 6'(mregs[ir[19:16]] + imm);
    if (t == T_ALU)
    begin
      case (op[2:0])
        3'd0: r = a + b;
        3'd1: r = a - b;
        3'd2: r = a & b;
        3'd3: r = a | b;
        3'd4: r = a ^ b;
        3'd5: r = a << b[4:0];
        3'd6: r = a >> b[4:0];
        default: r = b;
      endcase
      model_write(ir[23:20], r);
    end
    else if (t == T_MOV)
      model_write(ir[23:20], a);
    else if (t == T_LOAD)
      model_write(ir[23:20], mmem[addr]);
    else if (t == T_STORE)
      mmem[addr] = mregs[ir[23:20]];
  endfunction

  function automatic bit may_return();
    if (return_mode == 0)
      return 1'b1;
    if (return_mode == 1)
      return rand_below(2) == 0;
    if (hold_left > 0)
    begin
      hold_left--;
      return 1'b0;
    end
    if (rand_below(8) == 0)
    begin
      hold_left = rand_below(40);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_retire();
    assert (exp_addr.size() != 0)
    else
    begin
      $display("ret_valid raised with no register write expected");
      errors++;
    end
    if (exp_addr.size() != 0)
    begin
      assert (ret_addr == exp_addr[0])
      else
      begin
        $display("Mismatch ret_addr: got %h expected %h", ret_addr, exp_addr[0]);
        errors++;
      end
      assert (ret_data == exp_data[0])
      else
      begin
        $display("Mismatch ret_data: got %h expected %h", ret_data, exp_data[0]);
        errors++;
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  // sender and receiver credit agents
  always @(posedge clk_i)
  begin
    if (rst)
    begin
      in_valid   <= 1'b0;
      ret_credit <= 1'b0;
    end
    else
    begin
      cycles++;
      if (in_credit)
        credits++;
      assert (credits <= QUEUE_DEPTH && credits >= 0)
      else
      begin
        $display("sender credit count left its range: %0d", credits);
        errors++;
      end
      if (ret_valid)
      begin
        check_retire();
        owed++;
      end
      if (send_q.size() > 0 && credits > 0 && (!send_random || rand_below(4) != 0))
      begin
        in_valid <= 1'b1;
        in_instr <= send_q[0];
        model_step(send_q.pop_front());
        credits--;
        sent_total++;
      end
      else
        in_valid <= 1'b0;
      if (owed > 0 && may_return())
      begin
        ret_credit <= 1'b1;
        owed--;
      end
      else
        ret_credit <= 1'b0;
    end
  end

  task automatic finish_test(input string name, input int errs_before);
    do
      @(negedge clk_i);
    while (!(send_q.size() == 0 && exp_addr.size() == 0 && credits == QUEUE_DEPTH));
    if (errors == errs_before)
    begin
      pass_count++;
      $display("test %s: ok", name);
    end
    else
    begin
      fail_count++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  function automatic logic [31:0] random_instr();
    int kind;
    kind = rand_below(5);
    case (kind)
      0: return make_instr(T_ALU, 4'(rand_below(16)), 4'(rand_below(16)),
                           4'(rand_below(16)), 4'(rand_below(16)), 12'(next_rand()));
      1: return make_instr(T_MOV, 4'h0, 4'(rand_below(16)), 4'(rand_below(16)), 4'h0, 12'h0);
      2: return make_instr(T_LOAD, 4'h0, 4'(rand_below(16)), 4'(rand_below(16)), 4'h0,
                           12'(rand_below(64)));
      3: return make_instr(T_STORE, 4'h0, 4'(rand_below(16)), 4'(rand_below(16)), 4'h0,
                           12'(rand_below(64)));
      default: return {4'h0, 28'(next_rand())};
    endcase
  endfunction

  initial
  begin : main
    int e;
    int d;
    int ld;
    int imm;
    rng_state   = 32'hc51;
    clk_i       = 1'b0;
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_instr    = '0;
    ret_credit  = 1'b0;
    credits     = QUEUE_DEPTH;
    owed        = 0;
    hold_left   = 0;
    errors      = 0;
    pass_count  = 0;
    fail_count  = 0;
    cycles      = 0;
    sent_total  = 0;
    return_mode = 0;
    send_random = 1'b0;
    foreach (mregs[i])
      mregs[i] = '0;
    foreach (mmem[i])
      mmem[i] = '0;
    repeat (8) @(posedge clk_i);
    rst <= 1'b0;

    e = errors;
    repeat (20)
    begin
      @(posedge clk_i);
      assert (!ret_valid && !in_credit)
      else
      begin
        $display("output active while idle after reset");
        errors++;
      end
    end
    finish_test("reset", e);

    e = errors;
    for (int i = 0; i < 4; i++)
      send_q.push_back(make_instr(T_ALU, 4'h8, 4'(i), 4'(i), 4'h0, 12'(next_rand())));
    for (int i = 0; i < 40; i++)
      send_q.push_back(make_instr(T_ALU, 4'(rand_below(8)), 4'(rand_below(4)),
                                  4'(rand_below(4)), 4'(rand_below(4)), 12'h0));
    finish_test("alu forwarding", e);

    e = errors;
    for (int i = 0; i < 60; i++)
    begin
      if (rand_below(2) == 0)
        send_q.push_back(make_instr(T_ALU, 4'(8 + rand_below(8)), 4'(rand_below(8)),
                                    4'(rand_below(8)), 4'(rand_below(8)), 12'(next_rand())));
      else
        send_q.push_back(make_instr(T_MOV, 4'h0, 4'(rand_below(8)), 4'(rand_below(8)),
                                    4'h0, 12'h0));
    end
    finish_test("immediate and mov", e);

    e = errors;
    send_q.push_back(make_instr(T_ALU, 4'h8, 4'd4, 4'd4, 4'h0, 12'(rand_below(64))));
    send_q.push_back(make_instr(T_ALU, 4'h8, 4'd5, 4'd5, 4'h0, 12'(rand_below(64))));
    for (int i = 0; i < 20; i++)
    begin
      d   = rand_below(4);
      ld  = rand_below(4);
      imm = rand_below(64);
      send_q.push_back(make_instr(T_STORE, 4'h0, 4'(d), 4'(4 + i % 2), 4'h0, 12'(imm)));
      send_q.push_back(make_instr(T_LOAD, 4'h0, 4'(ld), 4'(4 + i % 2), 4'h0, 12'(imm)));
      // direct load-use as ALU source or as store data
      if (rand_below(2) == 0)
        send_q.push_back(make_instr(T_ALU, 4'h0, 4'(rand_below(4)), 4'(ld), 4'(ld), 12'h0));
      else
        send_q.push_back(make_instr(T_STORE, 4'h0, 4'(ld), 4'd5, 4'h0, 12'(rand_below(64))));
    end
    finish_test("load and store", e);

    e = errors;
    return_mode = 2;
    for (int i = 0; i < 60; i++)
      send_q.push_back(random_instr());
    finish_test("retire back-pressure", e);

    e = errors;
    return_mode = 1;
    send_random = 1'b1;
    for (int i = 0; i < 300; i++)
      send_q.push_back(random_instr());
    finish_test("random mix", e);

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // limit grows with the number of instructions sent
  initial
  begin : watchdog
    while (cycles <= 40 * sent_total + 200)
      @(posedge clk_i);
    $display("timeout after %0d cycles with %0d register writes still expected",
             cycles, exp_addr.size());
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/instr_queue.sv
rtl/hazard.sv
rtl/exec_pipe.sv
rtl/retire_port.sv
rtl/core_top.sv
tb/core_properties.sv
tb/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat tb.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): tb.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f tb.f

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q '^sim passed$$'

clean:
	rm -rf $(BUILD)
